//--- hw/fetch_pkg.sv
package fetch_pkg;

    // machine word width, shared by addresses and instructions
    localparam int WORD_W = 32;

    typedef logic [WORD_W-1:0] word_t;

    // cp0 exception codes, only the ones the fetch stage can raise
    typedef enum logic [4:0] {
        EXC_NONE = 5'h00,
        // address error on instruction load
        EXC_ADEL = 5'h04
    } exc_code_t;

    // kseg1 boot rom entry
    localparam word_t RESET_VECTOR = 32'hbfc0_0000;

    // kseg0/kseg1 fixed mapping drops the top three bits
    localparam word_t PHYS_MASK = 32'h1fff_ffff;

    // bytes per instruction, also the pc step
    localparam int INST_BYTES = 4;

    // sram-like size field
    localparam int BUS_SIZE_W = 2;

    // size code for a full word access
    localparam logic [BUS_SIZE_W-1:0] BUS_SIZE_WORD = 2'b10;

endpackage

//--- hw/pc_unit.sv
`timescale 1ns/1ps

module pc_unit (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             redirect,
    input  fetch_pkg::word_t redirect_target,
    input  logic             fetch_done,
    input  logic             fetch_fault,
    output fetch_pkg::word_t pc,
    output logic             pc_halted
);

    import fetch_pkg::*;

    word_t pc_q;
    logic  halted_q;
    word_t pc_seq;

    // next sequential fetch address
    assign pc_seq = pc_q + word_t'(INST_BYTES);

    // redirect wins over everything and a fault freezes the pc
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q     <= RESET_VECTOR;
            halted_q <= 1'b0;
        end else begin
            if (redirect) begin
                pc_q     <= redirect_target;
                halted_q <= 1'b0;
            end else if (fetch_fault) begin
                // keep the faulting pc for the exception handler
                halted_q <= 1'b1;
            end else if (fetch_done) begin
                pc_q <= pc_seq;
            end
        end
    end

    assign pc        = pc_q;
    assign pc_halted = halted_q;

    // one result per fetch and never both kinds at once
    a_done_fault_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(fetch_done && fetch_fault)
    ) else $error("pc_unit: fetch_done and fetch_fault high together");

    // a completed fetch while halted means the fetch unit ignored the halt
    a_no_done_halted: assert property (
        @(posedge clk) disable iff (!rst_n)
        pc_halted |-> !fetch_done
    ) else $error("pc_unit: fetch completed while halted");

endmodule

//--- hw/inst_fetch.sv
`timescale 1ns/1ps

module inst_fetch (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                fetch_en,
    input  fetch_pkg::word_t    pc,
    input  logic                pc_halted,
    input  logic                redirect,

    // sram-like instruction port
    output logic                inst_req,
    output logic                inst_wr,
    output logic [fetch_pkg::BUS_SIZE_W-1:0] inst_size,
    output fetch_pkg::word_t    inst_addr,
    output fetch_pkg::word_t    inst_wdata,
    input  fetch_pkg::word_t    inst_rdata,
    input  logic                inst_addr_ok,
    input  logic                inst_data_ok,

    // result towards decode
    output logic                fetch_valid,
    output fetch_pkg::word_t    fetch_inst,
    output fetch_pkg::word_t    fetch_pc,
    output fetch_pkg::exc_code_t fetch_exc,

    // completion back to the pc unit
    output logic                fetch_done,
    output logic                fetch_fault
);

    import fetch_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE      = 2'd0,
        S_WAIT_ADDR = 2'd1,
        S_WAIT_DATA = 2'd2
    } state_t;

    state_t state;
    state_t state_nxt;

    logic   discard_q;
    logic   discard_nxt;
    logic   fault_q;
    word_t  req_pc;

    logic   aligned;
    logic   can_start;
    logic   issue;
    logic   fault_detect;
    logic   data_hit;
    logic   live_pc;

    // instruction addresses must be word aligned
    assign aligned = (pc[1:0] == 2'b00);

    // a new fetch may start only with nothing in flight or pending;
    // a redirect cycle is skipped since pc is about to change
    assign can_start = (state == S_IDLE) && fetch_en && !pc_halted
                       && !fault_q && !redirect;

    assign issue        = can_start && aligned;
    assign fault_detect = can_start && !aligned;

    // read only, the write side is tied off
    assign inst_wr    = 1'b0;
    assign inst_wdata = '0;
    assign inst_size  = BUS_SIZE_WORD;

    // req held through WAIT_ADDR, even in a redirect cycle
    assign inst_req = issue || (state == S_WAIT_ADDR);

    // idle drives the live pc, otherwise the latched request pc
    assign live_pc   = (state == S_IDLE) && !fault_q;
    assign inst_addr = (live_pc ? pc : req_pc) & PHYS_MASK;

    // bus state machine
    always_comb begin
        state_nxt   = state;
        discard_nxt = discard_q;
        case (state)
            S_IDLE: begin
                if (issue) begin
                    if (inst_addr_ok && !inst_data_ok) begin
                        state_nxt   = S_WAIT_DATA;
                        discard_nxt = 1'b0;
                    end else if (!inst_addr_ok) begin
                        state_nxt = S_WAIT_ADDR;
                    end
                    // zero latency slave, done within the cycle
                end
            end
            S_WAIT_ADDR: begin
                if (inst_addr_ok) begin
                    if (inst_data_ok) begin
                        state_nxt = S_IDLE;
                    end else begin
                        state_nxt   = S_WAIT_DATA;
                        // accepted under a redirect, so the data is stale
                        discard_nxt = redirect;
                    end
                end else if (redirect) begin
                    // not accepted yet, just drop it
                    state_nxt = S_IDLE;
                end
            end
            S_WAIT_DATA: begin
                if (inst_data_ok) begin
                    state_nxt   = S_IDLE;
                    discard_nxt = 1'b0;
                end else if (redirect) begin
                    discard_nxt = 1'b1;
                end
            end
            default: begin
                state_nxt   = S_IDLE;
                discard_nxt = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            discard_q <= 1'b0;
            fault_q   <= 1'b0;
        end else begin
            state     <= state_nxt;
            discard_q <= discard_nxt;
            // misaligned pc reported one cycle later
            fault_q   <= fault_detect;
        end
    end

    // label for the returned word or the fault
    always_ff @(posedge clk) begin
        if (issue || fault_detect) begin
            req_pc <= pc;
        end
    end

    assign data_hit = inst_data_ok && !discard_q;

    // anything completing in a redirect cycle belongs to the old path
    assign fetch_valid = !redirect && (fault_q || data_hit);
    assign fetch_inst  = fault_q ? '0 : inst_rdata;
    assign fetch_pc    = live_pc ? pc : req_pc;
    assign fetch_exc   = fault_q ? EXC_ADEL : EXC_NONE;

    assign fetch_done  = fetch_valid && !fault_q;
    assign fetch_fault = fetch_valid && fault_q;

    // held request keeps its address until accepted
    a_addr_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (inst_req && !inst_addr_ok && !redirect) |=> (inst_req && $stable(inst_addr))
    ) else $error("inst_fetch: request changed before acceptance");

    // data only answers an accepted request
    a_no_data_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == S_IDLE && !(inst_req && inst_addr_ok)) |-> !inst_data_ok
    ) else $error("inst_fetch: data return with no request outstanding");

endmodule

//--- hw/fetch_front.sv
`timescale 1ns/1ps

module fetch_front (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                fetch_en,
    input  logic                redirect,
    input  fetch_pkg::word_t    redirect_target,

    // sram-like instruction port
    output logic                inst_req,
    output logic                inst_wr,
    output logic [fetch_pkg::BUS_SIZE_W-1:0] inst_size,
    output fetch_pkg::word_t    inst_addr,
    output fetch_pkg::word_t    inst_wdata,
    input  fetch_pkg::word_t    inst_rdata,
    input  logic                inst_addr_ok,
    input  logic                inst_data_ok,

    // result towards decode
    output logic                fetch_valid,
    output fetch_pkg::word_t    fetch_inst,
    output fetch_pkg::word_t    fetch_pc,
    output fetch_pkg::exc_code_t fetch_exc
);

    import fetch_pkg::*;

    word_t pc;
    logic  pc_halted;
    logic  fetch_done;
    logic  fetch_fault;

    pc_unit u_pc_unit (
        .clk             (clk),
        .rst_n           (rst_n),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .fetch_done      (fetch_done),
        .fetch_fault     (fetch_fault),
        .pc              (pc),
        .pc_halted       (pc_halted)
    );

    // bus master, also owns the decode strobe
    inst_fetch u_inst_fetch (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_en     (fetch_en),
        .pc           (pc),
        .pc_halted    (pc_halted),
        .redirect     (redirect),
        .inst_req     (inst_req),
        .inst_wr      (inst_wr),
        .inst_size    (inst_size),
        .inst_addr    (inst_addr),
        .inst_wdata   (inst_wdata),
        .inst_rdata   (inst_rdata),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok),
        .fetch_valid  (fetch_valid),
        .fetch_inst   (fetch_inst),
        .fetch_pc     (fetch_pc),
        .fetch_exc    (fetch_exc),
        .fetch_done   (fetch_done),
        .fetch_fault  (fetch_fault)
    );

endmodule

//--- tests/inst_mem_model.sv
`timescale 1ns/1ps

module inst_mem_model #(
    parameter int unsigned SEED = 0
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             inst_req,
    input  logic                             inst_wr,
    input  logic [fetch_pkg::BUS_SIZE_W-1:0] inst_size,
    input  fetch_pkg::word_t                 inst_addr,
    output logic                             inst_addr_ok,
    output logic                             inst_data_ok,
    output fetch_pkg::word_t                 inst_rdata,
    output int                               protocol_errors
);

    import fetch_pkg::*;

    integer seed;
    int     addr_cnt;
    int     data_dly;
    int     data_cnt;
    logic   pending;
    word_t  pend_addr;
    logic   zero_ret;

    initial begin
        seed            = SEED;
        protocol_errors = 0;
    end

    // accept once the address wait has run out
    assign inst_addr_ok = inst_req && (addr_cnt == 0);
    // zero latency return in the acceptance cycle
    assign zero_ret     = inst_addr_ok && (data_dly == 0) && !pending;
    assign inst_data_ok = (pending && data_cnt == 0) || zero_ret;
    // contents are the inverted physical address
    assign inst_rdata   = pending ? ~pend_addr : ~inst_addr;

    always @(posedge clk) begin
        if (!rst_n) begin
            addr_cnt <= int'($unsigned($random(seed)) % 32'd4);
            data_dly <= int'($unsigned($random(seed)) % 32'd4);
            data_cnt <= 0;
            pending  <= 1'b0;
        end else begin
            if (pending) begin
                if (data_cnt == 0) begin
                    pending <= 1'b0;
                end else begin
                    data_cnt <= data_cnt - 1;
                end
            end
            if (inst_req && !inst_addr_ok) begin
                addr_cnt <= addr_cnt - 1;
            end
            if (inst_addr_ok) begin
                if (pending && data_cnt != 0) begin
                    $display("memory model: second request accepted while one is outstanding");
                    protocol_errors <= protocol_errors + 1;
                end
                addr_cnt <= int'($unsigned($random(seed)) % 32'd4);
                data_dly <= int'($unsigned($random(seed)) % 32'd4);
                if (data_dly != 0) begin
                    pending   <= 1'b1;
                    data_cnt  <= data_dly - 1;
                    pend_addr <= inst_addr;
                end
            end
            if (inst_req && (inst_wr || inst_size != BUS_SIZE_WORD)) begin
                $display("memory model: request is not a word read");
                protocol_errors <= protocol_errors + 1;
            end
        end
    end

endmodule

//--- tests/tb_fetch_front.sv
`timescale 1ns/1ps

module tb_fetch_front;

    import fetch_pkg::*;

    localparam int unsigned RAND_SEED = 32'hcb6e;

    logic                  clk;
    logic                  rst_n;
    logic                  fetch_en;
    logic                  redirect;
    word_t                 redirect_target;
    logic                  inst_req;
    logic                  inst_wr;
    logic [BUS_SIZE_W-1:0] inst_size;
    word_t                 inst_addr;
    word_t                 inst_wdata;
    word_t                 inst_rdata;
    logic                  inst_addr_ok;
    logic                  inst_data_ok;
    logic                  fetch_valid;
    word_t                 fetch_inst;
    word_t                 fetch_pc;
    exc_code_t             fetch_exc;
    int                    mem_errors;

    integer seed;
    string  test_name;
    int     errors;
    int     checks;
    int     tests_run;
    int     tests_failed;
    int     valid_count;
    int     fault_count;
    word_t  exp_pc;
    logic   halted_exp;
    logic   quiet_window;
    logic   seen_req;
    word_t  first_req_addr;

    fetch_front DUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .fetch_en        (fetch_en),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .inst_req        (inst_req),
        .inst_wr         (inst_wr),
        .inst_size       (inst_size),
        .inst_addr       (inst_addr),
        .inst_wdata      (inst_wdata),
        .inst_rdata      (inst_rdata),
        .inst_addr_ok    (inst_addr_ok),
        .inst_data_ok    (inst_data_ok),
        .fetch_valid     (fetch_valid),
        .fetch_inst      (fetch_inst),
        .fetch_pc        (fetch_pc),
        .fetch_exc       (fetch_exc)
    );

    inst_mem_model #(.SEED(RAND_SEED)) u_mem (
        .clk             (clk),
        .rst_n           (rst_n),
        .inst_req        (inst_req),
        .inst_wr         (inst_wr),
        .inst_size       (inst_size),
        .inst_addr       (inst_addr),
        .inst_addr_ok    (inst_addr_ok),
        .inst_data_ok    (inst_data_ok),
        .inst_rdata      (inst_rdata),
        .protocol_errors (mem_errors)
    );

    always #20 clk = ~clk;

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_exc(input string name, input exc_code_t expected,
                             input exc_code_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAILED %s: expected %s, actual %s", name, expected.name(), actual.name());
        end
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("%s: %s", test_name, what);
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout in %s while waiting for %s", test_name, what);
        $display(">>> FAIL");
        $finish;
    endtask

    task automatic wait_fetches(input int n, input int limit);
        int target;
        int cycles;
        target = valid_count + n;
        cycles = 0;
        while (valid_count < target) begin
            @(posedge clk);
            cycles++;
            if (cycles > limit) begin
                abort_on_timeout("fetch_valid");
            end
        end
    endtask

    task automatic send_redirect(input word_t target);
        @(posedge clk);
        redirect        <= 1'b1;
        redirect_target <= target;
        @(posedge clk);
        redirect        <= 1'b0;
    endtask

    task automatic close_test(input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, errors - errors_before);
        end
    endtask

    // reference model sampled mid-cycle where outputs are settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (inst_wr !== 1'b0) begin
                report_error("inst_wr was driven high");
            end
            if (inst_size !== BUS_SIZE_WORD) begin
                report_error("inst_size is not the word size");
            end
            check_word({test_name, " inst_wdata"}, '0, inst_wdata);
            if (inst_req) begin
                if (!seen_req) begin
                    first_req_addr = inst_addr;
                    seen_req       = 1'b1;
                end
                if (halted_exp) begin
                    report_error("inst_req issued after an address error");
                end
                if (quiet_window) begin
                    report_error("inst_req issued with fetch_en low");
                end
                check_word({test_name, " inst_addr"}, exp_pc & PHYS_MASK, inst_addr);
            end
            if (quiet_window && fetch_valid) begin
                report_error("fetch_valid arrived with fetch_en low");
            end
            if (redirect) begin
                // the old path is abandoned, so nothing may complete here
                if (fetch_valid) begin
                    report_error("fetch_valid raised in a redirect cycle");
                end
                exp_pc     = redirect_target;
                halted_exp = 1'b0;
            end else if (fetch_valid) begin
                check_word({test_name, " fetch_pc"}, exp_pc, fetch_pc);
                if (exp_pc[1:0] == 2'b00) begin
                    check_word({test_name, " fetch_inst"}, ~(exp_pc & PHYS_MASK), fetch_inst);
                    check_exc({test_name, " fetch_exc"}, EXC_NONE, fetch_exc);
                    exp_pc = exp_pc + 32'd4;
                end else begin
                    check_word({test_name, " fetch_inst"}, '0, fetch_inst);
                    check_exc({test_name, " fetch_exc"}, EXC_ADEL, fetch_exc);
                    halted_exp = 1'b1;
                    fault_count++;
                end
                valid_count++;
            end
        end
    end

    initial begin
        int    errs;
        int    faults;
        word_t target;

        clk             = 1'b0;
        rst_n           = 1'b0;
        fetch_en        = 1'b0;
        redirect        = 1'b0;
        redirect_target = '0;
        seed            = RAND_SEED;
        errors          = 0;
        checks          = 0;
        tests_run       = 0;
        tests_failed    = 0;
        valid_count     = 0;
        fault_count     = 0;
        exp_pc          = RESET_VECTOR;
        halted_exp      = 1'b0;
        quiet_window    = 1'b0;
        seen_req        = 1'b0;
        first_req_addr  = '0;
        test_name       = "reset";

        repeat (16) @(posedge clk);
        rst_n    <= 1'b1;
        fetch_en <= 1'b1;

        test_name = "first_fetch";
        errs = errors;
        wait_fetches(1, 50);
        check_word("first_fetch first inst_addr", RESET_VECTOR & PHYS_MASK, first_req_addr);
        close_test(errs);

        test_name = "sequential";
        errs = errors;
        wait_fetches(200, 200 * 10);
        close_test(errs);

        test_name = "redirect";
        errs = errors;
        for (int i = 0; i < 40; i++) begin
            repeat (int'($unsigned($random(seed)) % 32'd12)) @(posedge clk);
            target = word_t'($random(seed)) & 32'hffff_fffc;
            send_redirect(target);
            wait_fetches(2, 40);
        end
        close_test(errs);

        test_name = "misaligned";
        errs = errors;
        faults = fault_count;
        target = (word_t'($random(seed)) & 32'hffff_fffc) | 32'h0000_0002;
        send_redirect(target);
        wait_fetches(1, 40);
        // monitor flags any request while halted
        repeat (30) @(posedge clk);
        if (fault_count - faults != 1) begin
            report_error("expected exactly one address error result");
        end
        send_redirect(RESET_VECTOR + 32'h100);
        wait_fetches(3, 60);
        close_test(errs);

        test_name = "fetch_disable";
        errs = errors;
        @(posedge clk);
        fetch_en <= 1'b0;
        // let an in-flight fetch drain
        repeat (12) @(posedge clk);
        quiet_window = 1'b1;
        repeat (50) @(posedge clk);
        quiet_window = 1'b0;
        fetch_en <= 1'b1;
        wait_fetches(4, 60);
        close_test(errs);

        test_name = "bus_protocol";
        errs = errors;
        if (mem_errors != 0) begin
            report_error($sformatf("memory model saw %0d protocol violations", mem_errors));
        end
        close_test(errs);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- fetch_front.f
hw/fetch_pkg.sv
hw/pc_unit.sv
hw/inst_fetch.sv
hw/fetch_front.sv
tests/inst_mem_model.sv
tests/tb_fetch_front.sv

//--- Makefile
# Verilator build for the fetch front end testbench

VERILATOR ?= verilator
TOP       ?= tb_fetch_front
FILELIST  ?= fetch_front.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= >>> PASS

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)
